//--- source/mm_pkg.sv
// shared types for the outer-product matrix kernel
// matrix side is fixed here because every packed beat and row type is sized by it
// lane values are signed, accumulators wrap modulo 2^ACC_W
package mm_pkg;

  // ====================
  // sizes
  // ====================

  // lanes per beat, also the side of C
  localparam int MATRIX_DIM = 4;
  // one element of A or B
  localparam int LANE_W = 16;
  // one accumulator, one element of C
  localparam int ACC_W = 32;
  // products per job
  localparam int PROD_CNT_W = 8;

  // ====================
  // input side
  // ====================

  // single signed element
  typedef logic signed [LANE_W-1:0] lane_t;

  // one column of A or one row of B, lane 0 in the low bits
  typedef lane_t [MATRIX_DIM-1:0] lane_vec_t;

  // raw beat as it arrives at the kernel
  typedef struct packed {
    lane_vec_t a_col;
    lane_vec_t b_row;
    logic      last;
  } mm_beat_t;

  // load overwrites the accumulators, acc adds into them
  typedef enum logic {
    MM_OP_LOAD = 1'b0,
    MM_OP_ACC  = 1'b1
  } mm_op_e;

  // beat after decode, tagged with its opcode
  typedef struct packed {
    mm_op_e    op;
    lane_vec_t a_col;
    lane_vec_t b_row;
    logic      last;
  } mm_step_t;

  // ====================
  // output side
  // ====================

  // one row of C, column 0 in the low bits
  typedef logic [MATRIX_DIM-1:0][ACC_W-1:0] c_row_t;

  // full C matrix, row 0 in the low bits
  typedef c_row_t [MATRIX_DIM-1:0] c_mat_t;

endpackage

//--- source/mm_kernel_ctrl.sv
// a rising edge of i_ap_start opens a job of i_num_products products
// a count of 0 runs one product; start edges during a job are ignored
`timescale 1ns/1ps

module mm_kernel_ctrl import mm_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  i_ap_start,
  input  logic [PROD_CNT_W-1:0] i_num_products,
  input  logic                  i_row_last,
  output logic                  o_run_active,
  output logic                  o_ap_idle,
  output logic                  o_ap_done
);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } ctrl_state_e;

  ctrl_state_e           state_q;
  logic                  start_q;
  logic                  start_pulse;
  logic [PROD_CNT_W-1:0] prod_target_q;
  logic [PROD_CNT_W-1:0] prod_done_q;
  logic                  final_row;

  // ====================
  // start edge
  // ====================

  // level in, one-cycle pulse out
  assign start_pulse = i_ap_start & ~start_q;

  // last row of the final product of this job
  assign final_row = i_row_last &&
                     (prod_done_q == prod_target_q - PROD_CNT_W'(1));

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q       <= 1'b0;
      state_q       <= ST_IDLE;
      prod_target_q <= PROD_CNT_W'(1);
      prod_done_q   <= '0;
    end else begin
      start_q <= i_ap_start;
      case (state_q)
        ST_IDLE: begin
          if (start_pulse) begin
            state_q     <= ST_RUN;
            prod_done_q <= '0;
            // zero products behaves as one
            prod_target_q <= (i_num_products == '0) ? PROD_CNT_W'(1) : i_num_products;
          end
        end
        default: begin
          // one finished product per last row
          if (final_row) begin
            state_q <= ST_IDLE;
          end else if (i_row_last) begin
            prod_done_q <= prod_done_q + PROD_CNT_W'(1);
          end
        end
      endcase
    end
  end

  assign o_run_active = (state_q == ST_RUN);
  assign o_ap_idle    = (state_q == ST_IDLE);
  // done shares its cycle with the last row
  assign o_ap_done    = (state_q == ST_RUN) && final_row;

  // finished products stay below the job target while a job runs
  a_count_in_range : assert property (@(posedge ap_clk) disable iff (areset)
    o_run_active |-> (prod_done_q < prod_target_q));

  a_no_done_in_idle : assert property (@(posedge ap_clk) disable iff (areset)
    o_ap_done |-> !o_ap_idle ##1 o_ap_idle);

endmodule

//--- source/mm_decode.sv
// beat register and opcode tagging
// beats outside a run are dropped, there is no back-pressure
`timescale 1ns/1ps

module mm_decode import mm_pkg::*; (
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     i_run_active,
  input  logic     i_beat_valid,
  input  mm_beat_t i_beat,
  output logic     o_step_valid,
  output mm_step_t o_step
);

  logic     beat_accept;
  // next accepted beat opens a new product
  logic     open_q;
  logic     step_valid_q;
  mm_step_t step_q;

  assign beat_accept = i_beat_valid & i_run_active;

  // ====================
  // control
  // ====================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      step_valid_q <= 1'b0;
      open_q       <= 1'b1;
    end else begin
      step_valid_q <= beat_accept;
      // rearm between jobs so the first beat after start loads
      if (!i_run_active) begin
        open_q <= 1'b1;
      end else if (beat_accept) begin
        // after a last beat the following one loads again
        open_q <= i_beat.last;
      end
    end
  end

  // ====================
  // payload
  // ====================

  always_ff @(posedge ap_clk) begin
    if (beat_accept) begin
      step_q.op    <= open_q ? MM_OP_LOAD : MM_OP_ACC;
      step_q.a_col <= i_beat.a_col;
      step_q.b_row <= i_beat.b_row;
      step_q.last  <= i_beat.last;
    end
  end

  assign o_step_valid = step_valid_q;
  assign o_step       = step_q;

endmodule

//--- source/mm_execute.sv
// square multiply-accumulate array that adds one outer product per step
// sums wrap modulo 2^ACC_W; o_mat holds only until the next step arrives
`timescale 1ns/1ps

module mm_execute import mm_pkg::*; (
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     i_step_valid,
  input  mm_step_t i_step,
  output logic     o_mat_valid,
  output c_mat_t   o_mat
);

  c_mat_t acc_q;
  // products of the current step before the add
  c_mat_t prod;
  logic   mat_valid_q;

  // signed lane product sign-extended or cut to accumulator width
  function automatic logic [ACC_W-1:0] lane_mul(input lane_t a, input lane_t b);
    logic signed [2*LANE_W-1:0] full;
    full = (2*LANE_W)'(a) * (2*LANE_W)'(b);
    return ACC_W'(full);
  endfunction

  // ====================
  // products
  // ====================

  // entry (r,c) pairs lane r of the A column with lane c of the B row
  always_comb begin
    for (int r = 0; r < MATRIX_DIM; r++) begin
      for (int c = 0; c < MATRIX_DIM; c++) begin
        prod[r][c] = lane_mul(i_step.a_col[r], i_step.b_row[c]);
      end
    end
  end

  // ====================
  // accumulators
  // ====================

  always_ff @(posedge ap_clk) begin
    if (i_step_valid) begin
      for (int r = 0; r < MATRIX_DIM; r++) begin
        for (int c = 0; c < MATRIX_DIM; c++) begin
          // first beat of a product discards the previous sums
          if (i_step.op == MM_OP_LOAD) begin
            acc_q[r][c] <= prod[r][c];
          end else begin
            acc_q[r][c] <= acc_q[r][c] + prod[r][c];
          end
        end
      end
    end
  end

  // strobe lines up with the accumulators that include the last step
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      mat_valid_q <= 1'b0;
    end else begin
      mat_valid_q <= i_step_valid & i_step.last;
    end
  end

  assign o_mat_valid = mat_valid_q;
  assign o_mat       = acc_q;

endmodule

//--- source/mm_result.sv
// holds one finished matrix and streams it out a row per cycle
// a new matrix may only arrive on or after the cycle of the final row
`timescale 1ns/1ps

module mm_result import mm_pkg::*; (
  input  logic   ap_clk,
  input  logic   areset,
  input  logic   i_mat_valid,
  input  c_mat_t i_mat,
  output logic   o_c_valid,
  output c_row_t o_c_row,
  output logic   o_c_last
);

  localparam int ROW_CNT_W = (MATRIX_DIM > 1) ? $clog2(MATRIX_DIM) : 1;

  c_mat_t               mat_buf_q;
  logic [ROW_CNT_W-1:0] row_q;
  logic                 busy_q;
  logic                 row_is_last;

  assign row_is_last = (row_q == ROW_CNT_W'(MATRIX_DIM - 1));

  // ====================
  // buffer
  // ====================

  // overwriting on the final row is safe, that row is already on the output
  always_ff @(posedge ap_clk) begin
    if (i_mat_valid) begin
      mat_buf_q <= i_mat;
    end
  end

  // ====================
  // row counter
  // ====================

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      busy_q <= 1'b0;
      row_q  <= '0;
    end else if (i_mat_valid) begin
      // restart from row 0 for the new matrix
      busy_q <= 1'b1;
      row_q  <= '0;
    end else if (busy_q) begin
      if (row_is_last) begin
        busy_q <= 1'b0;
        row_q  <= '0;
      end else begin
        row_q <= row_q + ROW_CNT_W'(1);
      end
    end
  end

  assign o_c_valid = busy_q;
  assign o_c_row   = mat_buf_q[row_q];
  assign o_c_last  = busy_q & row_is_last;

  // products shorter than MATRIX_DIM beats would cut the drain short
  a_no_overrun : assert property (@(posedge ap_clk) disable iff (areset)
    i_mat_valid |-> (!busy_q || row_is_last));

endmodule

//--- source/mm_kernel.sv
// matrix kernel top, ctrl -> decode -> execute -> result
// beats are plain strobes, outputs cannot be stalled
// up to two products in flight, one draining and one accumulating
`timescale 1ns/1ps

module mm_kernel import mm_pkg::*; (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  i_ap_start,
  input  logic [PROD_CNT_W-1:0] i_num_products,
  input  logic                  i_beat_valid,
  input  mm_beat_t              i_beat,
  output logic                  o_ap_idle,
  output logic                  o_ap_done,
  output logic                  o_c_valid,
  output c_row_t                o_c_row,
  output logic                  o_c_last
);

  // ====================
  // internal links
  // ====================

  logic     run_active;
  logic     step_valid;
  mm_step_t step;
  logic     mat_valid;
  c_mat_t   mat;
  // final row of each product, counted by ctrl
  logic     row_last_pulse;

  mm_kernel_ctrl u_ctrl (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .i_ap_start     (i_ap_start),
    .i_num_products (i_num_products),
    .i_row_last     (row_last_pulse),
    .o_run_active   (run_active),
    .o_ap_idle      (o_ap_idle),
    .o_ap_done      (o_ap_done)
  );

  mm_decode u_decode (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .i_run_active (run_active),
    .i_beat_valid (i_beat_valid),
    .i_beat       (i_beat),
    .o_step_valid (step_valid),
    .o_step       (step)
  );

  mm_execute u_execute (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .i_step_valid (step_valid),
    .i_step       (step),
    .o_mat_valid  (mat_valid),
    .o_mat        (mat)
  );

  mm_result u_result (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .i_mat_valid (mat_valid),
    .i_mat       (mat),
    .o_c_valid   (o_c_valid),
    .o_c_row     (o_c_row),
    .o_c_last    (row_last_pulse)
  );

  assign o_c_last = row_last_pulse;

endmodule

//--- test/tb_clock_gen.sv
// free running clock and a synchronous reset held for RESET_CYCLES rising edges
// reset drops 1 ns after the last of those edges
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 2
) (
  output logic o_ap_clk,
  output logic o_areset
);

  initial begin
    o_ap_clk = 1'b0;
    forever #(HALF_PERIOD) o_ap_clk = ~o_ap_clk;
  end

  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_ap_clk);
    #1;
    o_areset = 1'b0;
  end

endmodule

//--- test/tb_mm_kernel.sv
// matrix kernel testbench driven by the records in test/mm_patterns.txt
// inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
// a job header waits until the model sees the kernel idle again
`timescale 1ns/1ps

module tb_mm_kernel import mm_pkg::*; ();

  localparam int PAT_DEPTH   = 64;
  localparam int CLK_PERIOD  = 4;
  // row 0 follows the last beat by this many cycles
  localparam int ROW_LATENCY = 3;

  logic                  ap_clk;
  logic                  areset;
  logic                  ap_start;
  logic [PROD_CNT_W-1:0] num_products;
  logic                  beat_valid;
  mm_beat_t              beat;
  logic                  ap_idle;
  logic                  ap_done;
  logic                  c_valid;
  c_row_t                c_row;
  logic                  c_last;

  // tag nibble, flag nibble, 128 bit payload
  logic [135:0] pat_mem [0:PAT_DEPTH-1];
  c_row_t       exp_row_q[$];
  // cycle in which each last beat is on the bus
  int           last_cyc_q[$];
  logic [31:0]  rng_state = 32'h4f44_37a4;
  int           cyc = 0;
  int           watch_cycles = 0;
  int           row_errs = 0;
  int           ctrl_errs = 0;
  int           strobe_errs = 0;
  int           timing_errs = 0;
  int           other_errs = 0;

  // ====================
  // control model
  // ====================
  logic exp_idle = 1'b1;
  logic start_seen = 1'b0;
  int   prod_target = 1;
  int   prods_seen = 0;
  int   row_idx = 0;

  tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(2)) u_clk (
    .o_ap_clk (ap_clk),
    .o_areset (areset)
  );

  mm_kernel dut0 (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .i_ap_start     (ap_start),
    .i_num_products (num_products),
    .i_beat_valid   (beat_valid),
    .i_beat         (beat),
    .o_ap_idle      (ap_idle),
    .o_ap_done      (ap_done),
    .o_c_valid      (c_valid),
    .o_c_row        (c_row),
    .o_c_last       (c_last)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_row(input c_row_t got, input c_row_t exp);
    if (got !== exp) begin
      $display("FAIL @%0t: product %0d row %0d is %h, expected %h",
               $time, prods_seen, row_idx, got, exp);
      row_errs++;
    end
  endtask

  task automatic check_ctrl(input logic idle, input logic done,
                            input logic exp_i, input logic exp_d);
    if (idle !== exp_i || done !== exp_d) begin
      $display("FAIL @%0t: idle/done are %b/%b, expected %b/%b",
               $time, idle, done, exp_i, exp_d);
      ctrl_errs++;
    end
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("FAIL @%0t: %s is %b, expected %b", $time, name, got, exp);
      strobe_errs++;
    end
  endtask

  task automatic check_latency(input int got);
    if (got != ROW_LATENCY) begin
      $display("FAIL @%0t: row 0 came %0d cycles after the last beat, expected %0d",
               $time, got, ROW_LATENCY);
      timing_errs++;
    end
  endtask

  task automatic report_counts();
    $display("errors: row %0d, control %0d, strobe %0d, timing %0d, other %0d",
             row_errs, ctrl_errs, strobe_errs, timing_errs, other_errs);
  endtask

  task automatic load_patterns();
    int n_beats = 0;
    int n_rows = 0;
    int n_jobs = 0;
    for (int i = 0; i < PAT_DEPTH; i++) begin
      // entries past the file read as end records
      pat_mem[i] = {4'hF, 4'h0, 128'(i)};
    end
    $readmemh("test/mm_patterns.txt", pat_mem);
    for (int i = 0; i < PAT_DEPTH; i++) begin
      case (pat_mem[i][135:132])
        4'h1: n_jobs++;
        4'h2, 4'h4: n_beats++;
        4'h3: n_rows++;
        default: ;
      endcase
    end
    // up to 3 idle cycles ahead of each beat plus start and drain slack
    watch_cycles = 4 * (4 * n_beats + n_rows + 2 * n_jobs + 16);
  endtask

  task automatic wait_idle();
    while (!exp_idle) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  // low for one cycle, then high, so the kernel sees a rising edge
  task automatic start_job(input logic [PROD_CNT_W-1:0] n);
    wait_idle();
    ap_start = 1'b0;
    @(posedge ap_clk);
    #1;
    num_products = n;
    ap_start     = 1'b1;
    @(posedge ap_clk);
    #1;
  endtask

  task automatic send_beat(input logic [135:0] rec, input logic in_job);
    int gap;
    rng_state = xorshift32(rng_state);
    gap = int'(rng_state[1:0]);
    repeat (gap) begin
      @(posedge ap_clk);
      #1;
    end
    beat.a_col = rec[127:64];
    beat.b_row = rec[63:0];
    beat.last  = rec[128];
    beat_valid = 1'b1;
    if (in_job && rec[128]) begin
      last_cyc_q.push_back(cyc);
    end
    @(posedge ap_clk);
    #1;
    beat_valid = 1'b0;
  endtask

  // one falling-edge look at the outputs, then advance the model
  task automatic watch_outputs();
    logic   exp_done;
    logic   exp_last;
    c_row_t exp_row;
    exp_done = 1'b0;
    exp_last = 1'b0;
    if (c_valid) begin
      exp_last = (row_idx == MATRIX_DIM - 1);
      if (exp_row_q.size() == 0) begin
        $display("unexpected row at %0t while no expected row was pending", $time);
        other_errs++;
      end else begin
        exp_row = exp_row_q.pop_front();
        check_row(c_row, exp_row);
      end
      if (row_idx == 0 && last_cyc_q.size() != 0) begin
        check_latency(cyc - last_cyc_q.pop_front());
      end
      if (exp_last) begin
        exp_done = !exp_idle && (prods_seen == prod_target - 1);
        prods_seen++;
        row_idx = 0;
      end else begin
        row_idx++;
      end
    end
    check_strobe(c_last, exp_last, "o_c_last");
    check_ctrl(ap_idle, ap_done, exp_idle, exp_done);
    // done returns to idle and only an idle kernel takes a start edge
    if (exp_done) begin
      exp_idle = 1'b1;
    end else if (exp_idle && ap_start && !start_seen) begin
      exp_idle    = 1'b0;
      prods_seen  = 0;
      prod_target = (num_products == '0) ? 1 : int'(num_products);
    end
    start_seen = ap_start;
  endtask

  always @(posedge ap_clk) begin
    cyc <= cyc + 1;
  end

  always @(negedge ap_clk) begin
    if (!areset) begin
      watch_outputs();
    end
  end

  // ====================
  // watchdog
  // ====================
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge ap_clk);
    $display("watchdog ran out after %0d cycles, the test did not finish", watch_cycles);
    other_errs++;
    report_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [135:0] rec;
    int           pc;
    logic         walking;
    ap_start     = 1'b0;
    num_products = '0;
    beat_valid   = 1'b0;
    beat         = '0;
    load_patterns();
    wait (!areset);
    @(posedge ap_clk);
    #1;
    pc      = 0;
    walking = 1'b1;
    while (walking) begin
      rec = pat_mem[pc];
      pc++;
      case (rec[135:132])
        4'h1: start_job(rec[PROD_CNT_W-1:0]);
        4'h2: send_beat(rec, 1'b1);
        4'h3: exp_row_q.push_back(c_row_t'(rec[127:0]));
        4'h4: begin
          // beat while idle must be dropped
          wait_idle();
          send_beat(rec, 1'b0);
        end
        4'hF: walking = 1'b0;
        default: begin
          $display("pattern entry %0d has an unknown record type", pc - 1);
          other_errs++;
          walking = 1'b0;
        end
      endcase
      if (pc >= PAT_DEPTH) begin
        walking = 1'b0;
      end
    end
    while (exp_row_q.size() != 0 || !exp_idle) begin
      @(posedge ap_clk);
    end
    // room for any stray row to show up
    repeat (2 * MATRIX_DIM) @(posedge ap_clk);
    report_counts();
    if (row_errs + ctrl_errs + strobe_errs + timing_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
source/mm_pkg.sv
source/mm_kernel_ctrl.sv
source/mm_decode.sv
source/mm_execute.sv
source/mm_result.sv
source/mm_kernel.sv
test/tb_clock_gen.sv
test/tb_mm_kernel.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the matrix kernel testbench with Verilator
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mm_kernel \
  -Mdir obj_dir -o tb_mm_kernel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mm_kernel > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- test/mm_patterns.txt
// columns: tag, flag, 32 hex digits of payload; tag 1 job start with count in low byte,
// tag 2 beat (flag = last, A lanes 3..0 then B lanes 3..0), 3 C row (cols 3..0), 4 idle beat, F end
// beats before any start must give no rows
4_0_0001_0002_0003_0004_0005_0006_0007_0008
4_1_0011_0012_0013_0014_0015_0016_0017_0018
// job of count 0 runs one product
1_0_00000000_00000000_00000000_00000000
2_0_0004_0003_0002_0001_0000_0000_0000_0001
2_0_0000_0000_0001_0000_0003_0002_0001_0000
2_0_0001_0001_0001_0001_0001_0000_0000_0000
2_1_0000_0000_0000_0002_0001_0001_0001_0001
3_0_00000003_00000002_00000002_00000003
3_0_00000004_00000002_00000001_00000002
3_0_00000001_00000000_00000000_00000003
3_0_00000001_00000000_00000000_00000004
// job of 3 products, start stays high afterwards
1_0_00000000_00000000_00000000_00000003
// signed lanes, C[0][0] wraps to zero
2_0_0000_0002_FFFF_8000_0000_FFFD_0005_8000
2_0_0000_0002_FFFF_8000_0000_FFFD_0005_8000
2_0_0000_0002_FFFF_8000_0000_FFFD_0005_8000
2_1_0000_0002_FFFF_8000_0000_FFFD_0005_8000
3_0_00000000_00060000_FFF60000_00000000
3_0_00000000_0000000C_FFFFFFEC_00020000
3_0_00000000_FFFFFFE8_00000028_FFFC0000
3_0_00000000_00000000_00000000_00000000
// first beat loads, so no residue from the product above
2_0_0000_0000_0000_0001_0000_0000_0000_0007
2_0_0000_0000_0001_0000_0000_0000_0007_0000
2_0_0000_0001_0000_0000_0000_0007_0000_0000
2_1_0001_0000_0000_0000_0007_0000_0000_0000
3_0_00000000_00000000_00000000_00000007
3_0_00000000_00000000_00000007_00000000
3_0_00000000_00000007_00000000_00000000
3_0_00000007_00000000_00000000_00000000
2_0_FFFE_0000_0000_0003_0000_0000_0000_0001
2_0_0000_0000_0000_0000_0009_0009_0009_0009
2_0_0000_0000_0004_0000_0000_FFFF_0000_0000
2_1_0001_0001_0001_0001_000A_0000_0000_0000
3_0_0000000A_00000000_00000000_00000003
3_0_0000000A_FFFFFFFC_00000000_00000000
3_0_0000000A_00000000_00000000_00000000
3_0_0000000A_00000000_00000000_FFFFFFFE
// start still high, no new edge, so this beat is dropped
4_1_0001_0001_0001_0001_0001_0001_0001_0001
F_0_00000000_00000000_00000000_00000000
